//--- common/sensor_buf_pkg.sv
////////////////////////////////////////
// sensor_buf_pkg
// widths, beat structs, drain config and
// drain state encoding shared by the
// sensor capture buffer
////////////////////////////////////////

package sensor_buf_pkg;

    localparam int PX_W      = 16;                  // sensor pixel word
    localparam int OUT_W     = 64;                  // memory side word, four pixels
    localparam int PAGE_BITS = 2;                   // four line pages

    // one pclk beat from the sensor channel
    typedef struct packed {
        logic            valid;                     // data qualifier
        logic            last_in_line;              // final pixel of the line
        logic [PX_W-1:0] data;                      // pixel value
    } px_in_t;

    // one mclk beat toward the memory writer
    typedef struct packed {
        logic             valid;                    // word strobe, no back-pressure
        logic             line_end;                 // last word of a line
        logic [OUT_W-1:0] data;                     // earliest pixel in low bits
    } mem_out_t;

    // drain setup, static during a frame
    typedef struct packed {
        logic [9:0]  line_words;                    // 64-bit words per line, 1..128
        logic [15:0] n_lines;                       // lines per frame
    } drain_cfg_t;

    typedef enum logic [2:0] {
        DR_IDLE,                                    // wait for start
        DR_SET,                                     // reset read page
        DR_WAIT,                                    // wait for a full page
        DR_READ,                                    // burst of buf_rd
        DR_NEXT,                                    // step to next page
        DR_DONE                                     // frame finished
    } drain_state_t;

endpackage

//--- src/pulse_cross_clock.sv
////////////////////////////////////////
// pulse_cross_clock
// single-cycle pulse transfer between two
// clocks by toggle synchronization, busy
// until the far side has acknowledged
////////////////////////////////////////
`timescale 1ns/1ps

module pulse_cross_clock (
    input  logic rst,                               // sync, held over a few cycles of both clocks
    input  logic src_clk,
    input  logic dst_clk,
    input  logic in_pulse,                          // src_clk domain
    output logic out_pulse,                         // dst_clk domain
    output logic busy                               // src_clk domain
);

    logic       src_tgl;                            // flips once per accepted pulse
    logic [2:0] dst_sync;                           // two sync flops plus history
    logic [1:0] ack_sync;                           // dst view brought back to src

    always_ff @(posedge src_clk) begin
        if (rst) begin
            src_tgl  <= 1'b0;
            ack_sync <= 2'b00;
        end else begin
            ack_sync <= {ack_sync[0], dst_sync[1]}; // return path
            if (in_pulse && !busy)
                src_tgl <= ~src_tgl;                // pulse dropped while busy
        end
    end

    always_ff @(posedge dst_clk) begin
        if (rst)
            dst_sync <= 3'b000;
        else
            dst_sync <= {dst_sync[1:0], src_tgl};
    end

    assign out_pulse = dst_sync[2] ^ dst_sync[1];   // edge of synced toggle
    assign busy      = src_tgl ^ ack_sync[1];       // not yet seen by dst

endmodule

//--- membuf/mcntrl_buf_wr.sv
////////////////////////////////////////
// mcntrl_buf_wr
// dual-clock paged line RAM, 16-bit write
// side, 64-bit read side with page and
// address counters, two-cycle read
////////////////////////////////////////
`timescale 1ns/1ps

module mcntrl_buf_wr #(
    parameter int WADDR_WIDTH = 9                   // write address bits per page
) (
    input  logic                                             ext_clk,
    input  logic [sensor_buf_pkg::PAGE_BITS+WADDR_WIDTH-1:0] ext_waddr, // {page, addr}
    input  logic                                             ext_we,
    input  logic [sensor_buf_pkg::PX_W-1:0]                  ext_data_in,
    input  logic                                             rclk,
    input  logic                                             rst,
    input  logic                                             rpage_set,
    input  logic                                             page_next,
    input  logic                                             rd,
    output logic [sensor_buf_pkg::OUT_W-1:0]                 data_out
);

    import sensor_buf_pkg::*;

    localparam int WTOP    = PAGE_BITS + WADDR_WIDTH;
    localparam int RADDR_W = WTOP - 2;              // four pixels per read word
    localparam int DEPTH   = 1 << RADDR_W;

    // four 16-bit lanes per entry, lane 0 is the lowest write address
    logic [3:0][PX_W-1:0] ram [0:DEPTH-1];

    logic [PAGE_BITS-1:0]   rpage;                  // current read page
    logic [WADDR_WIDTH-3:0] raddr;                  // word within page
    logic [RADDR_W-1:0]     rd_addr_q;              // first read stage
    logic                   rd_q;                   // enable for second stage
    logic [OUT_W-1:0]       data_q;                 // registered RAM output

    // pixel side, one lane per cycle
    always_ff @(posedge ext_clk) begin
        if (ext_we)
            ram[ext_waddr[WTOP-1:2]][ext_waddr[1:0]] <= ext_data_in;
    end

    // read page and address control
    always_ff @(posedge rclk) begin
        if (rst) begin
            rpage <= '0;
            raddr <= '0;
            rd_q  <= 1'b0;
        end else begin
            rd_q <= rd;
            if (rpage_set) begin                    // start of frame
                rpage <= '0;
                raddr <= '0;
            end else if (page_next) begin           // line done
                rpage <= rpage + 1'b1;
                raddr <= '0;
            end else if (rd) begin
                raddr <= raddr + 1'b1;
            end
        end
    end

    // address stage then data stage
    always_ff @(posedge rclk) begin
        if (rd)
            rd_addr_q <= {rpage, raddr};
        if (rd_q)
            data_q <= ram[rd_addr_q];               // lanes pack low to high
    end

    assign data_out = data_q;

endmodule

//--- membuf/sensor_membuf.sv
////////////////////////////////////////
// sensor_membuf
// one-channel line buffer, pclk write
// pointers, page events handed across
// to mclk and pointer clear back to pclk
////////////////////////////////////////
`timescale 1ns/1ps

module sensor_membuf #(
    parameter int WADDR_WIDTH = 9
) (
    input  logic                             pclk,
    input  sensor_buf_pkg::px_in_t           px,         // pclk
    input  logic                             mclk,
    input  logic                             rst_wpntr,  // mclk, sync, active high
    input  logic                             rpage_set,  // mclk strobes from the drain
    input  logic                             rpage_next,
    input  logic                             buf_rd,
    output logic [sensor_buf_pkg::OUT_W-1:0] buf_dout,
    output logic                             page_done   // mclk, one per page
);

    import sensor_buf_pkg::*;

    logic [PAGE_BITS-1:0]   wpage;                  // page being filled
    logic [WADDR_WIDTH-1:0] waddr;                  // pixel within page
    logic [1:0]             rst_p_sync;             // reset into pclk
    logic [2:0]             clr_dly;                // rpage_set shaping, mclk
    logic                   wclr_p;                 // crossed pointer clear, pclk
    logic                   wpntr_clr;
    logic                   page_adv;               // page closes this beat
    logic                   page_adv_q;             // after last pixel is written

    always_ff @(posedge pclk) begin
        rst_p_sync <= {rst_p_sync[0], rst_wpntr};   // plain two-flop sync
    end

    always_ff @(posedge mclk) begin
        if (rst_wpntr) begin
            clr_dly <= 3'b000;
        end else begin
            clr_dly[0] <= rpage_set;
            clr_dly[1] <= clr_dly[0];
            clr_dly[2] <= clr_dly[1] & ~clr_dly[0]; // one pulse per set
        end
    end

    pulse_cross_clock u_wclr_cross (
        .rst       (rst_wpntr),
        .src_clk   (mclk),
        .dst_clk   (pclk),
        .in_pulse  (clr_dly[2]),
        .out_pulse (wclr_p),
        .busy      ()
    );

    assign wpntr_clr = rst_p_sync[1] | wclr_p;
    assign page_adv  = px.valid && (px.last_in_line || (&waddr)); // line end or full page

    always_ff @(posedge pclk) begin
        if (wpntr_clr) begin
            waddr      <= '0;
            wpage      <= '0;
            page_adv_q <= 1'b0;
        end else begin
            page_adv_q <= page_adv;
            if (px.valid && px.last_in_line)
                waddr <= '0;
            else if (px.valid)
                waddr <= waddr + 1'b1;              // wraps with the page on full
            if (page_adv)
                wpage <= wpage + 1'b1;
        end
    end

    pulse_cross_clock u_page_cross (
        .rst       (rst_wpntr),
        .src_clk   (pclk),
        .dst_clk   (mclk),
        .in_pulse  (page_adv_q),
        .out_pulse (page_done),
        .busy      ()
    );

    mcntrl_buf_wr #(
        .WADDR_WIDTH (WADDR_WIDTH)
    ) u_buf_wr (
        .ext_clk     (pclk),
        .ext_waddr   ({wpage, waddr}),
        .ext_we      (px.valid),
        .ext_data_in (px.data),
        .rclk        (mclk),
        .rst         (rst_wpntr),
        .rpage_set   (rpage_set),
        .page_next   (rpage_next),
        .rd          (buf_rd),
        .data_out    (buf_dout)
    );

endmodule

//--- src/membuf_drain.sv
////////////////////////////////////////
// membuf_drain
// mclk FSM that reads finished line pages
// and streams 64-bit words with line
// end marks and a frame done pulse
////////////////////////////////////////
`timescale 1ns/1ps

module membuf_drain (
    input  logic                             mclk,
    input  logic                             rst_wpntr,
    input  sensor_buf_pkg::drain_cfg_t       cfg,
    input  logic                             start,
    input  logic                             page_done,
    input  logic [sensor_buf_pkg::OUT_W-1:0] buf_dout,
    output logic                             rpage_set,
    output logic                             rpage_next,
    output logic                             buf_rd,
    output sensor_buf_pkg::mem_out_t         out,
    output logic                             frame_done
);

    import sensor_buf_pkg::*;

    drain_state_t state;
    logic [2:0]   pend;                             // pages written but not drained
    logic [9:0]   word_cnt;                         // word within line
    logic [15:0]  line_cnt;                         // lines drained so far
    logic         last_word;
    logic [1:0]   out_vld;                          // follows buf_rd by two
    logic [1:0]   out_le;

    assign last_word = (word_cnt == cfg.line_words - 10'd1);

    always_ff @(posedge mclk) begin
        if (rst_wpntr) begin
            state    <= DR_IDLE;
            word_cnt <= '0;
            line_cnt <= '0;
        end else begin
            case (state)
                DR_IDLE: if (start) state <= DR_SET;
                DR_SET: begin
                    line_cnt <= '0;
                    state    <= DR_WAIT;
                end
                DR_WAIT: begin
                    word_cnt <= '0;
                    if (pend != 3'd0) state <= DR_READ;
                end
                DR_READ: begin
                    word_cnt <= word_cnt + 10'd1;
                    if (last_word) state <= DR_NEXT;
                end
                DR_NEXT: begin
                    line_cnt <= line_cnt + 16'd1;
                    if (line_cnt == cfg.n_lines - 16'd1)
                        state <= DR_DONE;
                    else
                        state <= DR_WAIT;
                end
                default: state <= DR_IDLE;          // DR_DONE lasts one cycle
            endcase
        end
    end

    // pending pages, in from the buffer, out on each rpage_next
    always_ff @(posedge mclk) begin
        if (rst_wpntr || state == DR_SET)
            pend <= '0;
        else if (page_done && !rpage_next)
            pend <= pend + 3'd1;
        else if (rpage_next && !page_done)
            pend <= pend - 3'd1;
    end

    always_ff @(posedge mclk) begin
        if (rst_wpntr) begin
            out_vld    <= 2'b00;
            out_le     <= 2'b00;
            frame_done <= 1'b0;
        end else begin
            out_vld    <= {out_vld[0], buf_rd};
            out_le     <= {out_le[0], buf_rd && last_word};
            frame_done <= (state == DR_DONE);       // one after last valid
        end
    end

    assign rpage_set  = (state == DR_SET);
    assign rpage_next = (state == DR_NEXT);
    assign buf_rd     = (state == DR_READ);

    assign out = '{valid: out_vld[1], line_end: out_le[1], data: buf_dout};

endmodule

//--- src/sensor_channel_top.sv
////////////////////////////////////////
// sensor_channel_top
// capture buffer for one sensor channel
// plus the mclk drain toward memory
////////////////////////////////////////
`timescale 1ns/1ps

module sensor_channel_top #(
    parameter int WADDR_WIDTH = 9                   // 512 pixels per page
) (
    input  logic                       mclk,
    input  logic                       rst_wpntr,   // mclk, sync, active high
    input  logic                       pclk,
    input  sensor_buf_pkg::px_in_t     px,          // pclk
    input  sensor_buf_pkg::drain_cfg_t cfg,         // stable during a frame
    input  logic                       start,       // mclk pulse
    output sensor_buf_pkg::mem_out_t   out,
    output logic                       frame_done
);

    import sensor_buf_pkg::*;

    logic             rpage_set;                    // drain to buffer strobes
    logic             rpage_next;
    logic             buf_rd;
    logic [OUT_W-1:0] buf_dout;                     // read data, 2 cycles after buf_rd
    logic             page_done;                    // one per completed line page

    sensor_membuf #(
        .WADDR_WIDTH (WADDR_WIDTH)
    ) u_sensor_membuf (
        .pclk       (pclk),
        .px         (px),
        .mclk       (mclk),
        .rst_wpntr  (rst_wpntr),
        .rpage_set  (rpage_set),
        .rpage_next (rpage_next),
        .buf_rd     (buf_rd),
        .buf_dout   (buf_dout),
        .page_done  (page_done)
    );

    membuf_drain u_membuf_drain (
        .mclk       (mclk),
        .rst_wpntr  (rst_wpntr),
        .cfg        (cfg),
        .start      (start),
        .page_done  (page_done),
        .buf_dout   (buf_dout),
        .rpage_set  (rpage_set),
        .rpage_next (rpage_next),
        .buf_rd     (buf_rd),
        .out        (out),
        .frame_done (frame_done)
    );

endmodule

//--- sim/tb_sensor_channel.sv
////////////////////////////////////////
// tb_sensor_channel
// pixel stream in pclk, drained 64-bit
// words checked in mclk against packed
// reference pixels, several frames
////////////////////////////////////////
`timescale 1ns/1ps

module tb_sensor_channel;

    import sensor_buf_pkg::*;

    localparam int N_FRAMES = 4;

    logic       mclk;
    logic       pclk;
    logic       rst_wpntr;
    px_in_t     px;
    drain_cfg_t cfg;
    logic       start;
    mem_out_t   out;
    logic       frame_done;

    logic [PX_W-1:0] px_q[$];                       // pixels sent and not yet drained
    int              words_left;                    // words still due this frame
    int              lw_exp;                        // words per line this frame
    int              word_in_line;
    bit              done_due;                      // frame_done expected this cycle
    int              frames_seen;
    int              cyc;
    int              cyc_limit;

    sensor_channel_top #(
        .WADDR_WIDTH (9)
    ) u_sensor_channel_top (
        .mclk       (mclk),
        .rst_wpntr  (rst_wpntr),
        .pclk       (pclk),
        .px         (px),
        .cfg        (cfg),
        .start      (start),
        .out        (out),
        .frame_done (frame_done)
    );

    initial begin
        mclk = 1'b0;
        forever #10 mclk = ~mclk;                   // 20 ns
    end

    initial begin
        pclk = 1'b0;
        forever #13 pclk = ~pclk;                   // 26 ns pixel clock
    end

    // lines in each frame of the run
    function automatic int lines_in_frame(input int f);
        case (f)
            0:       return 4;
            1:       return 8;                      // twice the page count
            2:       return 5;
            default: return 3;
        endcase
    endfunction

    // pixels per line in each frame of the run
    function automatic int pixels_per_line(input int f);
        case (f)
            0:       return 64;
            1:       return 64;
            2:       return 32;
            default: return 128;
        endcase
    endfunction

    // packs four pixels with the earliest in the low lane
    function automatic logic [OUT_W-1:0] pack_pixels(input logic [PX_W-1:0] p0,
                                                     input logic [PX_W-1:0] p1,
                                                     input logic [PX_W-1:0] p2,
                                                     input logic [PX_W-1:0] p3);
        return {p3, p2, p1, p0};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input mem_out_t got, input mem_out_t exp);
        if (got !== exp)
            fail_run($sformatf("FAIL t=%0t out got=%b/%b/%h exp=%b/%b/%h", $time,
                               got.valid, got.line_end, got.data,
                               exp.valid, exp.line_end, exp.data));
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("FAIL t=%0t frame_done got=%b exp=%b", $time, got, exp));
    endtask

    // configure, start, stream the pixels, then wait for the drain
    task automatic run_frame(input int n_lines, input int line_px);
        int              ln;
        int              i;
        int              gap;
        int              seen0;
        logic [31:0]     rnd;
        @(posedge mclk);
        #2;
        cfg          = '{line_words: 10'(line_px / 4), n_lines: 16'(n_lines)};
        lw_exp       = line_px / 4;
        word_in_line = 0;
        words_left   = n_lines * line_px / 4;
        seen0        = frames_seen;
        start        = 1'b1;
        @(posedge mclk);
        #2 start = 1'b0;
        repeat (12) @(posedge pclk);                // pointer clear reaches pclk first
        for (ln = 0; ln < n_lines; ln++) begin
            for (i = 0; i < line_px; i++) begin
                gap = $urandom % 3;                 // idle beats before this pixel
                repeat (gap) begin
                    @(posedge pclk);
                    #2 px = '0;
                end
                rnd = $urandom;
                px_q.push_back(rnd[PX_W-1:0]);
                @(posedge pclk);
                #2;
                px = '{valid: 1'b1, last_in_line: (i == line_px - 1), data: rnd[PX_W-1:0]};
            end
        end
        @(posedge pclk);
        #2 px = '0;
        wait (frames_seen != seen0);
    endtask

    // output compare on each mclk edge
    always @(posedge mclk) begin : compare_out
        mem_out_t        exp;
        logic [PX_W-1:0] p0;
        logic [PX_W-1:0] p1;
        logic [PX_W-1:0] p2;
        logic [PX_W-1:0] p3;
        if (!rst_wpntr) begin
            check_done(frame_done, done_due);       // exactly one cycle after last word
            if (frame_done)
                frames_seen++;
            done_due = 1'b0;
            if (out.valid) begin
                if (words_left == 0 || px_q.size() < 4) begin
                    fail_run("output word appeared with no frame words pending");
                end else begin
                    p0  = px_q.pop_front();
                    p1  = px_q.pop_front();
                    p2  = px_q.pop_front();
                    p3  = px_q.pop_front();
                    exp = '{valid: 1'b1, line_end: (word_in_line == lw_exp - 1),
                            data: pack_pixels(p0, p1, p2, p3)};
                    check_word(out, exp);
                    word_in_line = (word_in_line == lw_exp - 1) ? 0 : word_in_line + 1;
                    words_left--;
                    if (words_left == 0)
                        done_due = 1'b1;
                end
            end
        end
    end

    always @(posedge mclk) begin
        cyc++;
        if (cyc >= cyc_limit) begin
            $display("timeout after %0d mclk cycles, the frame never completed", cyc);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    initial begin
        int f;
        int total_px;
        void'($urandom(32'ha9ba_2df7));
        total_px = 0;
        for (f = 0; f < N_FRAMES; f++)
            total_px += lines_in_frame(f) * pixels_per_line(f);
        cyc_limit    = 40 * total_px + 2000;
        cyc          = 0;
        rst_wpntr    = 1'b1;
        px           = '0;
        cfg          = '0;
        start        = 1'b0;
        words_left   = 0;
        lw_exp       = 1;
        word_in_line = 0;
        done_due     = 1'b0;
        frames_seen  = 0;
        repeat (3) @(posedge mclk);
        #2 rst_wpntr = 1'b0;
        repeat (30) @(posedge mclk);                // idle window with no output allowed
        for (f = 0; f < N_FRAMES; f++)
            run_frame(lines_in_frame(f), pixels_per_line(f));
        repeat (20) @(posedge mclk);                // no stray output after last frame
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- list.f
common/sensor_buf_pkg.sv
src/pulse_cross_clock.sv
membuf/mcntrl_buf_wr.sv
membuf/sensor_membuf.sv
src/membuf_drain.sv
src/sensor_channel_top.sv
sim/tb_sensor_channel.sv

//--- Bender.yml
package:
  name: sensor_channel

dependencies: {}

sources:
  - files:
      - common/sensor_buf_pkg.sv
      - src/pulse_cross_clock.sv
      - membuf/mcntrl_buf_wr.sv
      - membuf/sensor_membuf.sv
      - src/membuf_drain.sv
      - src/sensor_channel_top.sv
  - target: test
    files:
      - sim/tb_sensor_channel.sv
